/* logic/heapConfigPkg.sv */
// Heap configuration
// Sizes of the array heap and the types derived from them

package heapConfigPkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int HEAP_ARRAYS  = 4;                    // Arrays in the heap
  localparam int ARRAY_LENGTH = 8;                    // Elements per array
  localparam int DATA_BITS    = 12;                   // Element width

  // ------------------------------------------------------------
  // Derived types
  // ------------------------------------------------------------
  typedef logic [$clog2(HEAP_ARRAYS)-1:0]  arrayId;       // Array number
  typedef logic [$clog2(ARRAY_LENGTH)-1:0] elementIndex;  // Index within an array
  typedef logic [$clog2(ARRAY_LENGTH):0]   sizeCount;     // Size, 0 to ARRAY_LENGTH
  typedef logic [DATA_BITS-1:0]            elementWord;   // Element value
  typedef logic [HEAP_ARRAYS-1:0]          slotMask;      // One bit per array

endpackage

/* logic/heapOpsPkg.sv */
// Heap operations
// Opcodes of the request port and error codes of the response port

package heapOpsPkg;

  // ------------------------------------------------------------
  // Request opcodes
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    opAlloc,                                          // Allocate an array and return its number
    opFree,                                           // Release an array for reuse
    opWrite,                                          // Store one element
    opRead,                                           // Load one element
    opSize,                                           // Current array size
    opPush,                                           // Append at the end
    opPop,                                            // Remove from the end
    opAdd,                                            // Element plus data
    opSubtract,                                       // Element minus data
    opOr,                                             // Bitwise or
    opAnd,                                            // Bitwise and
    opXor                                             // Bitwise xor
  } heapOp;

  // ------------------------------------------------------------
  // Response error codes
  // ------------------------------------------------------------
  // Any error comes back with zero data and leaves the heap unchanged
  typedef enum logic [2:0] {
    errNone,                                          // Success
    errNotAllocated,                                  // Array not allocated
    errOutOfMemory,                                   // No array left to allocate
    errOutOfBounds,                                   // Index at or past the size
    errArrayFull,                                     // Push on a full array
    errArrayEmpty                                     // Pop on an empty array
  } heapError;

endpackage

/* logic/arraySlot.sv */
// Array slot
// Element storage and size of one array; checks bounds and performs
// the element operations, answering one cycle after select

module arraySlot (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       select,
  input  heapOpsPkg::heapOp          op,
  input  heapConfigPkg::elementIndex index,
  input  heapConfigPkg::elementWord  data,
  output logic                       done,
  output heapConfigPkg::elementWord  result,
  output heapOpsPkg::heapError       error
);

  heapConfigPkg::elementWord  elements [heapConfigPkg::ARRAY_LENGTH];
  heapConfigPkg::sizeCount    size;

  heapConfigPkg::sizeCount    nextSize;
  logic                       writeEnable;
  heapConfigPkg::elementIndex writeIndex;
  heapConfigPkg::elementWord  writeValue;
  heapConfigPkg::elementWord  nextResult;
  heapOpsPkg::heapError       nextError;
  heapConfigPkg::elementWord  current;
  heapConfigPkg::elementWord  aluValue;
  logic                       inBounds;

  assign current  = elements[index];
  assign inBounds = heapConfigPkg::sizeCount'(index) < size;

  always_comb begin
    case (op)
      heapOpsPkg::opAdd:      aluValue = current + data;   // Wraps at 12 bits
      heapOpsPkg::opSubtract: aluValue = current - data;
      heapOpsPkg::opOr:       aluValue = current | data;
      heapOpsPkg::opAnd:      aluValue = current & data;
      default:                aluValue = current ^ data;
    endcase
  end

  // ------------------------------------------------------------
  // Next state per operation
  // ------------------------------------------------------------
  always_comb begin
    nextSize    = size;
    writeEnable = 1'b0;
    writeIndex  = index;
    writeValue  = data;
    nextResult  = '0;
    nextError   = heapOpsPkg::errNone;
    case (op)
      heapOpsPkg::opAlloc: nextSize = '0;             // Reused arrays start empty
      heapOpsPkg::opWrite: begin
        writeEnable = 1'b1;
        nextResult  = data;
        if (!inBounds)
          nextSize = heapConfigPkg::sizeCount'(index) + 1'b1;
      end
      heapOpsPkg::opRead: begin
        if (inBounds) nextResult = current;
        else          nextError  = heapOpsPkg::errOutOfBounds;
      end
      heapOpsPkg::opSize: nextResult = heapConfigPkg::elementWord'(size);
      heapOpsPkg::opPush: begin
        if (size == heapConfigPkg::sizeCount'(heapConfigPkg::ARRAY_LENGTH)) begin
          nextError = heapOpsPkg::errArrayFull;
        end else begin
          writeEnable = 1'b1;
          writeIndex  = heapConfigPkg::elementIndex'(size);
          nextSize    = size + 1'b1;
          nextResult  = data;
        end
      end
      heapOpsPkg::opPop: begin
        if (size == '0) begin
          nextError = heapOpsPkg::errArrayEmpty;
        end else begin
          nextSize   = size - 1'b1;
          nextResult = elements[heapConfigPkg::elementIndex'(size - 1'b1)];  // Last element
        end
      end
      heapOpsPkg::opAdd, heapOpsPkg::opSubtract, heapOpsPkg::opOr,
      heapOpsPkg::opAnd, heapOpsPkg::opXor: begin
        if (inBounds) begin
          writeEnable = 1'b1;
          writeValue  = aluValue;
          nextResult  = aluValue;
        end else begin
          nextError = heapOpsPkg::errOutOfBounds;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      size <= '0;
      done <= 1'b0;
    end else begin
      done <= select && (op != heapOpsPkg::opAlloc);   // Allocator answers Alloc
      if (select)
        size <= nextSize;
    end
  end

  always_ff @(posedge clock) begin
    if (select && writeEnable)
      elements[writeIndex] <= writeValue;
    if (select) begin
      result <= nextResult;
      error  <= nextError;
    end
  end

endmodule

/* logic/arrayAllocator.sv */
// Array allocator
// Accepts one request at a time, tracks which arrays are allocated and
// answers Alloc, Free and unallocated accesses itself; routes the rest to a slot

module arrayAllocator (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     reqValid,
  output logic                     reqReady,
  input  heapOpsPkg::heapOp        reqOp,
  input  heapConfigPkg::arrayId    reqArray,
  input  heapConfigPkg::elementIndex reqIndex,
  input  heapConfigPkg::elementWord  reqData,
  input  logic                     respDone,
  output heapConfigPkg::slotMask   slotSelect,
  output heapOpsPkg::heapOp        slotOp,
  output heapConfigPkg::elementIndex slotIndex,
  output heapConfigPkg::elementWord  slotData,
  output logic                     ownValid,
  output heapConfigPkg::elementWord  ownResult,
  output heapOpsPkg::heapError     ownError
);

  logic                       busy;                   // Request in flight
  logic                       pending;                // Decision cycle
  heapOpsPkg::heapOp          opReg;
  heapConfigPkg::arrayId      arrayReg;
  heapConfigPkg::elementIndex indexReg;
  heapConfigPkg::elementWord  dataReg;

  heapConfigPkg::slotMask     allocated;              // Per-array allocated flag
  logic [$clog2(heapConfigPkg::HEAP_ARRAYS):0] freshCount;  // Never-used arrays handed out
  logic [$clog2(heapConfigPkg::HEAP_ARRAYS):0] freedTop;    // Entries on freed stack
  heapConfigPkg::arrayId      freedStack [heapConfigPkg::HEAP_ARRAYS];

  logic                       isAlloc;
  logic                       isFree;
  logic                       haveFreed;
  logic                       canAlloc;
  logic                       targetAllocated;
  heapConfigPkg::arrayId      allocId;

  assign reqReady = !busy;

  // ------------------------------------------------------------
  // Decision from the registered request
  // ------------------------------------------------------------
  assign isAlloc         = opReg == heapOpsPkg::opAlloc;
  assign isFree          = opReg == heapOpsPkg::opFree;
  assign haveFreed       = freedTop != '0;
  assign canAlloc        = haveFreed || (freshCount < heapConfigPkg::HEAP_ARRAYS);
  assign targetAllocated = allocated[arrayReg];
  // Reuse the most recently freed array before a fresh one
  assign allocId = haveFreed ? freedStack[heapConfigPkg::arrayId'(freedTop - 1'b1)]
                             : heapConfigPkg::arrayId'(freshCount);

  always_comb begin
    slotSelect = '0;
    if (pending) begin
      if (isAlloc && canAlloc)
        slotSelect = heapConfigPkg::slotMask'(1) << allocId;   // Slot clears its size
      else if (!isAlloc && !isFree && targetAllocated)
        slotSelect = heapConfigPkg::slotMask'(1) << arrayReg;
    end
  end

  assign slotOp    = opReg;
  assign slotIndex = indexReg;
  assign slotData  = dataReg;

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busy       <= 1'b0;
      pending    <= 1'b0;
      allocated  <= '0;
      freshCount <= '0;
      freedTop   <= '0;
      ownValid   <= 1'b0;
    end else begin
      pending  <= reqValid && reqReady;
      ownValid <= 1'b0;
      if (reqValid && reqReady)
        busy <= 1'b1;
      else if (respDone)
        busy <= 1'b0;                                 // Ready again next cycle
      if (pending) begin
        if (isAlloc) begin
          ownValid <= 1'b1;
          if (canAlloc) begin
            allocated[allocId] <= 1'b1;
            if (haveFreed)
              freedTop <= freedTop - 1'b1;
            else
              freshCount <= freshCount + 1'b1;
          end
        end else if (isFree) begin
          ownValid <= 1'b1;
          if (targetAllocated) begin
            allocated[arrayReg] <= 1'b0;              // Second free is refused
            freedTop            <= freedTop + 1'b1;
          end
        end else begin
          ownValid <= !targetAllocated;               // Slot answers otherwise
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Request and result registers
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reqValid && reqReady) begin
      opReg    <= reqOp;
      arrayReg <= reqArray;
      indexReg <= reqIndex;
      dataReg  <= reqData;
    end
    if (pending && isFree && targetAllocated)
      freedStack[heapConfigPkg::arrayId'(freedTop)] <= arrayReg;
    if (pending) begin
      ownResult <= (isAlloc && canAlloc) ? heapConfigPkg::elementWord'(allocId) : '0;
      if (isAlloc)
        ownError <= canAlloc ? heapOpsPkg::errNone : heapOpsPkg::errOutOfMemory;
      else
        ownError <= targetAllocated ? heapOpsPkg::errNone : heapOpsPkg::errNotAllocated;
    end
  end

endmodule

/* logic/responseCollector.sv */
// Response collector
// Registers the one valid result from the allocator or a slot and holds
// it on the response port until the caller takes it

module responseCollector (
  input  logic                      clock,
  input  logic                      resetN,
  input  logic                      ownValid,
  input  heapConfigPkg::elementWord ownResult,
  input  heapOpsPkg::heapError      ownError,
  input  heapConfigPkg::slotMask    slotDone,
  input  heapConfigPkg::elementWord slotResults [heapConfigPkg::HEAP_ARRAYS],
  input  heapOpsPkg::heapError      slotErrors  [heapConfigPkg::HEAP_ARRAYS],
  output logic                      respValid,
  input  logic                      respReady,
  output heapConfigPkg::elementWord respData,
  output heapOpsPkg::heapError      respError,
  output logic                      respDone
);

  heapConfigPkg::elementWord pickResult;
  heapOpsPkg::heapError      pickError;
  logic                      loadResp;

  // At most one source is valid per request
  always_comb begin
    pickResult = ownResult;
    pickError  = ownError;
    for (int i = 0; i < heapConfigPkg::HEAP_ARRAYS; i++) begin
      if (slotDone[i]) begin
        pickResult = slotResults[i];
        pickError  = slotErrors[i];
      end
    end
  end

  assign loadResp = ownValid || (|slotDone);
  assign respDone = respValid && respReady;           // Consume event

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      respValid <= 1'b0;
    else if (loadResp)
      respValid <= 1'b1;
    else if (respDone)
      respValid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (loadResp) begin
      respData  <= pickResult;
      respError <= pickError;
    end
  end

endmodule

/* logic/arrayHeap.sv */
// Array heap top level
// Allocator, one slot per array and the response collector

module arrayHeap (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       reqValid,
  output logic                       reqReady,
  input  heapOpsPkg::heapOp          reqOp,
  input  heapConfigPkg::arrayId      reqArray,
  input  heapConfigPkg::elementIndex reqIndex,
  input  heapConfigPkg::elementWord  reqData,
  output logic                       respValid,
  input  logic                       respReady,
  output heapConfigPkg::elementWord  respData,
  output heapOpsPkg::heapError       respError
);

  heapConfigPkg::slotMask     slotSelect;
  heapOpsPkg::heapOp          slotOp;
  heapConfigPkg::elementIndex slotIndex;
  heapConfigPkg::elementWord  slotData;
  heapConfigPkg::slotMask     slotDone;
  heapConfigPkg::elementWord  slotResult [heapConfigPkg::HEAP_ARRAYS];
  heapOpsPkg::heapError       slotError  [heapConfigPkg::HEAP_ARRAYS];
  logic                       ownValid;
  heapConfigPkg::elementWord  ownResult;
  heapOpsPkg::heapError       ownError;
  logic                       respDone;

  arrayAllocator u_allocator (
    .clock      (clock),
    .resetN     (resetN),
    .reqValid   (reqValid),
    .reqReady   (reqReady),
    .reqOp      (reqOp),
    .reqArray   (reqArray),
    .reqIndex   (reqIndex),
    .reqData    (reqData),
    .respDone   (respDone),
    .slotSelect (slotSelect),
    .slotOp     (slotOp),
    .slotIndex  (slotIndex),
    .slotData   (slotData),
    .ownValid   (ownValid),
    .ownResult  (ownResult),
    .ownError   (ownError)
  );

  // ------------------------------------------------------------
  // One slot per array, sharing the operation bus
  // ------------------------------------------------------------
  for (genvar i = 0; i < heapConfigPkg::HEAP_ARRAYS; i++) begin : gSlot
    arraySlot u_slot (
      .clock  (clock),
      .resetN (resetN),
      .select (slotSelect[i]),
      .op     (slotOp),
      .index  (slotIndex),
      .data   (slotData),
      .done   (slotDone[i]),
      .result (slotResult[i]),
      .error  (slotError[i])
    );
  end

  responseCollector u_collector (
    .clock       (clock),
    .resetN      (resetN),
    .ownValid    (ownValid),
    .ownResult   (ownResult),
    .ownError    (ownError),
    .slotDone    (slotDone),
    .slotResults (slotResult),
    .slotErrors  (slotError),
    .respValid   (respValid),
    .respReady   (respReady),
    .respData    (respData),
    .respError   (respError),
    .respDone    (respDone)
  );

endmodule

/* test/arrayHeap_chk.sv */
// Array heap handshake checks
// Bound into arrayHeap; response latency, hold under back-pressure and busy

module arrayHeapChk (
  input logic                      clock,
  input logic                      resetN,
  input logic                      reqValid,
  input logic                      reqReady,
  input logic                      respValid,
  input logic                      respReady,
  input heapConfigPkg::elementWord respData,
  input heapOpsPkg::heapError      respError
);

  // Response registered two edges after the accepting edge
  responseLatency: assert property (@(posedge clock) disable iff (!resetN)
    reqValid && reqReady |=> !respValid ##1 !respValid ##1 respValid)
    else $error("respValid did not rise two cycles after acceptance");

  responseHeld: assert property (@(posedge clock) disable iff (!resetN)
    respValid && !respReady |=> respValid && $stable(respData) && $stable(respError))
    else $error("Response changed while waiting for respReady");

  busyWhileResponding: assert property (@(posedge clock) disable iff (!resetN)
    respValid |-> !reqReady)
    else $error("reqReady high while a response is pending");

endmodule

bind arrayHeap arrayHeapChk u_chk (
  .clock     (clock),
  .resetN    (resetN),
  .reqValid  (reqValid),
  .reqReady  (reqReady),
  .respValid (respValid),
  .respReady (respReady),
  .respData  (respData),
  .respError (respError)
);

/* test/arrayHeapTb.sv */
// Array heap testbench
// Directed tests of allocation, element access, push/pop, arithmetic,
// free and reuse, and response back-pressure

module arrayHeapTb;

  localparam int PERIOD         = 100;
  localparam int REQUEST_COUNT  = 70;                 // Upper bound over all tests
  localparam int REQUEST_CYCLES = 6;                  // Accept to ready again
  localparam int MAX_STALL      = 6;                  // Longest back-pressure span
  localparam int WAIT_LIMIT     = 20;
  localparam int TEST_CYCLES    = 5 + REQUEST_COUNT * (REQUEST_CYCLES + MAX_STALL);

  logic                       clock;
  logic                       resetN;
  logic                       reqValid;
  logic                       reqReady;
  heapOpsPkg::heapOp          reqOp;
  heapConfigPkg::arrayId      reqArray;
  heapConfigPkg::elementIndex reqIndex;
  heapConfigPkg::elementWord  reqData;
  logic                       respValid;
  logic                       respReady;
  heapConfigPkg::elementWord  respData;
  heapOpsPkg::heapError       respError;

  arrayHeap u_arrayHeap (
    .clock     (clock),
    .resetN    (resetN),
    .reqValid  (reqValid),
    .reqReady  (reqReady),
    .reqOp     (reqOp),
    .reqArray  (reqArray),
    .reqIndex  (reqIndex),
    .reqData   (reqData),
    .respValid (respValid),
    .respReady (respReady),
    .respData  (respData),
    .respError (respError)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // ------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkWord(input string name, input heapConfigPkg::elementWord actual,
                           input heapConfigPkg::elementWord expected);
    if (actual !== expected)
      abortRun($sformatf("Error at time %0t: %s = 0x%0h, expected 0x%0h",
                         $time, name, actual, expected));
  endtask

  task automatic checkError(input string name, input heapOpsPkg::heapError actual,
                            input heapOpsPkg::heapError expected);
    if (actual !== expected)
      abortRun($sformatf("Error at time %0t: %s = %s, expected %s",
                         $time, name, actual.name(), expected.name()));
  endtask

  initial begin
    #(2 * TEST_CYCLES * PERIOD);
    abortRun("Watchdog expired before the tests finished");
  end

  // Reference model of the element operations with 12-bit wraparound
  function automatic heapConfigPkg::elementWord applyOp(input heapOpsPkg::heapOp op,
      input heapConfigPkg::elementWord a, input heapConfigPkg::elementWord b);
    int modulus;
    modulus = 1 << heapConfigPkg::DATA_BITS;
    case (op)
      heapOpsPkg::opAdd:
        return heapConfigPkg::elementWord'((int'(a) + int'(b)) % modulus);
      heapOpsPkg::opSubtract:
        return heapConfigPkg::elementWord'((int'(a) - int'(b) + modulus) % modulus);
      heapOpsPkg::opOr:       return a | b;
      heapOpsPkg::opAnd:      return a & b;
      heapOpsPkg::opXor:      return a ^ b;
      default:                return '0;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Request handshake between two falling edges
  // ------------------------------------------------------------
  task automatic sendRequest(input heapOpsPkg::heapOp op, input heapConfigPkg::arrayId arr,
      input heapConfigPkg::elementIndex idx, input heapConfigPkg::elementWord value,
      input int stall, output heapConfigPkg::elementWord data,
      output heapOpsPkg::heapError err);
    int waited;
    heapConfigPkg::elementWord heldData;
    heapOpsPkg::heapError      heldError;
    waited = 0;
    while (!reqReady) begin
      waited++;
      if (waited > WAIT_LIMIT)
        abortRun("reqReady stayed low, request could not be sent");
      @(negedge clock);
    end
    reqValid = 1'b1;
    reqOp    = op;
    reqArray = arr;
    reqIndex = idx;
    reqData  = value;
    @(negedge clock);                                 // Taken on the rising edge
    reqValid = 1'b0;
    waited   = 0;
    while (!respValid) begin
      waited++;
      if (waited > WAIT_LIMIT)
        abortRun("No response arrived for the request");
      @(negedge clock);
    end
    heldData  = respData;
    heldError = respError;
    repeat (stall) begin
      if (reqReady || !respValid)
        abortRun("Response handshake moved on while respReady was low");
      @(negedge clock);
      checkWord("respData", respData, heldData);
      checkError("respError", respError, heldError);
    end
    respReady = 1'b1;
    @(negedge clock);                                 // Consumed on the rising edge
    respReady = 1'b0;
    if (!reqReady || respValid)
      abortRun("Heap not ready again after the response was consumed");
    data = heldData;
    err  = heldError;
  endtask

  task automatic expectResponse(input heapOpsPkg::heapOp op, input heapConfigPkg::arrayId arr,
      input heapConfigPkg::elementIndex idx, input heapConfigPkg::elementWord value,
      input int stall, input heapConfigPkg::elementWord expData,
      input heapOpsPkg::heapError expErr);
    heapConfigPkg::elementWord data;
    heapOpsPkg::heapError      err;
    sendRequest(op, arr, idx, value, stall, data, err);
    checkError("respError", err, expErr);
    checkWord("respData", data, expData);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic allocOrderTest();
    for (int i = 0; i < heapConfigPkg::HEAP_ARRAYS; i++) begin
      expectResponse(heapOpsPkg::opRead, heapConfigPkg::arrayId'(i), 3'd0, 12'd0, 0,
                     12'd0, heapOpsPkg::errNotAllocated);
      expectResponse(heapOpsPkg::opAlloc, 2'd0, 3'd0, 12'd0, 0,
                     heapConfigPkg::elementWord'(i), heapOpsPkg::errNone);
    end
    expectResponse(heapOpsPkg::opAlloc, 2'd0, 3'd0, 12'd0, 0, 12'd0,
                   heapOpsPkg::errOutOfMemory);
  endtask

  task automatic writeReadSizeTest();
    heapConfigPkg::elementWord value;
    value = heapConfigPkg::elementWord'($urandom);
    expectResponse(heapOpsPkg::opWrite, 2'd0, 3'd2, value, 0, value, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opSize, 2'd0, 3'd0, 12'd0, 0, 12'd3, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opRead, 2'd0, 3'd2, 12'd0, 0, value, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opRead, 2'd0, 3'd5, 12'd0, 0, 12'd0,
                   heapOpsPkg::errOutOfBounds);
  endtask

  task automatic pushPopTest();
    heapConfigPkg::elementWord pushed [heapConfigPkg::ARRAY_LENGTH];
    for (int i = 0; i < heapConfigPkg::ARRAY_LENGTH; i++) begin
      pushed[i] = heapConfigPkg::elementWord'($urandom);
      expectResponse(heapOpsPkg::opPush, 2'd1, 3'd0, pushed[i], 0, pushed[i],
                     heapOpsPkg::errNone);
    end
    expectResponse(heapOpsPkg::opPush, 2'd1, 3'd0, 12'h5a5, 0, 12'd0, heapOpsPkg::errArrayFull);
    expectResponse(heapOpsPkg::opSize, 2'd1, 3'd0, 12'd0, 0, 12'd8, heapOpsPkg::errNone);
    for (int i = heapConfigPkg::ARRAY_LENGTH - 1; i >= 0; i--)
      expectResponse(heapOpsPkg::opPop, 2'd1, 3'd0, 12'd0, 0, pushed[i], heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opPop, 2'd1, 3'd0, 12'd0, 0, 12'd0, heapOpsPkg::errArrayEmpty);
  endtask

  task automatic arithmeticTest();
    heapOpsPkg::heapOp         ops [5];
    heapConfigPkg::elementWord a;
    heapConfigPkg::elementWord b;
    heapConfigPkg::elementWord expected;
    ops = '{heapOpsPkg::opAdd, heapOpsPkg::opSubtract, heapOpsPkg::opOr,
            heapOpsPkg::opAnd, heapOpsPkg::opXor};
    for (int i = 0; i < 5; i++) begin
      a        = heapConfigPkg::elementWord'($urandom);
      b        = heapConfigPkg::elementWord'($urandom);
      expected = applyOp(ops[i], a, b);
      expectResponse(heapOpsPkg::opWrite, 2'd2, heapConfigPkg::elementIndex'(i), a, 0, a,
                     heapOpsPkg::errNone);
      expectResponse(ops[i], 2'd2, heapConfigPkg::elementIndex'(i), b, 0, expected,
                     heapOpsPkg::errNone);
      expectResponse(heapOpsPkg::opRead, 2'd2, heapConfigPkg::elementIndex'(i), 12'd0, 0,
                     expected, heapOpsPkg::errNone);
    end
    // Index 7 lies past the five written elements
    expectResponse(heapOpsPkg::opAdd, 2'd2, 3'd7, 12'd1, 0, 12'd0, heapOpsPkg::errOutOfBounds);
  endtask

  task automatic freeReuseTest();
    expectResponse(heapOpsPkg::opPush, 2'd1, 3'd0, 12'h123, 0, 12'h123, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opWrite, 2'd3, 3'd4, 12'h456, 0, 12'h456, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opFree, 2'd1, 3'd0, 12'd0, 0, 12'd0, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opFree, 2'd3, 3'd0, 12'd0, 0, 12'd0, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opRead, 2'd1, 3'd0, 12'd0, 0, 12'd0,
                   heapOpsPkg::errNotAllocated);
    expectResponse(heapOpsPkg::opFree, 2'd1, 3'd0, 12'd0, 0, 12'd0,
                   heapOpsPkg::errNotAllocated);
    // Freed numbers come back last in, first out
    expectResponse(heapOpsPkg::opAlloc, 2'd0, 3'd0, 12'd0, 0, 12'd3, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opAlloc, 2'd0, 3'd0, 12'd0, 0, 12'd1, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opSize, 2'd3, 3'd0, 12'd0, 0, 12'd0, heapOpsPkg::errNone);
    expectResponse(heapOpsPkg::opSize, 2'd1, 3'd0, 12'd0, 0, 12'd0, heapOpsPkg::errNone);
  endtask

  task automatic backPressureTest();
    heapConfigPkg::elementWord value;
    for (int i = 0; i < 4; i++) begin
      value = heapConfigPkg::elementWord'($urandom);
      expectResponse(heapOpsPkg::opWrite, 2'd0, heapConfigPkg::elementIndex'(i), value,
                     $urandom_range(MAX_STALL, 1), value, heapOpsPkg::errNone);
      expectResponse(heapOpsPkg::opRead, 2'd0, heapConfigPkg::elementIndex'(i), 12'd0,
                     $urandom_range(MAX_STALL, 1), value, heapOpsPkg::errNone);
    end
    expectResponse(heapOpsPkg::opSize, 2'd0, 3'd0, 12'd0, $urandom_range(MAX_STALL, 1),
                   12'd4, heapOpsPkg::errNone);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    resetN    = 1'b0;
    reqValid  = 1'b0;
    reqOp     = heapOpsPkg::opAlloc;
    reqArray  = '0;
    reqIndex  = '0;
    reqData   = '0;
    respReady = 1'b0;
    void'($urandom(32'h22a0191d));
    repeat (3) @(negedge clock);
    resetN = 1'b1;
    @(negedge clock);
    if (!reqReady || respValid)
      abortRun("Heap not idle after reset");
    allocOrderTest();
    writeReadSizeTest();
    pushPopTest();
    arithmeticTest();
    freeReuseTest();
    backPressureTest();
    $display("TEST OK");
    $finish;
  end

endmodule

/* files.f */
logic/heapConfigPkg.sv
logic/heapOpsPkg.sv
logic/arraySlot.sv
logic/arrayAllocator.sv
logic/responseCollector.sv
logic/arrayHeap.sv
test/arrayHeap_chk.sv
test/arrayHeapTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the array heap testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module arrayHeapTb \
  -f files.f -o arrayHeapSim || { echo "Build failed"; exit 1; }

./obj_dir/arrayHeapSim 2>&1 | tee sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without passing"; exit 1; }
exit 0
